/* Makefile */
TOP := apb_stub_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f tb.f --top-module $(TOP)

obj_dir/V$(TOP): tb.f hdl/*.sv hdl/*.svh sim/*.sv
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'all tests passed'

clean:
	rm -rf obj_dir

/* hdl/apb_slave_stub.sv */
`timescale 1ns/10ps
`include "apb_stub_macros.svh"

module apb_slave_stub (
    input  logic                         aclk,
    input  logic                         aresetn,

    // APB4 slave side
    input  logic                         i_psel,
    input  logic                         i_penable,
    input  logic [`APB_ADDR_WIDTH-1:0]   i_paddr,
    input  logic                         i_pwrite,
    input  logic [`APB_DATA_WIDTH-1:0]   i_pwdata,
    input  logic [`APB_STRB_WIDTH-1:0]   i_pstrb,
    input  logic [2:0]                   i_pprot,
    output logic [`APB_DATA_WIDTH-1:0]   o_prdata,
    output logic                         o_pslverr,
    output logic                         o_pready,

    // Command packet out
    output logic                         o_cmd_valid,
    input  logic                         i_cmd_ready,
    output apb_stub_pkg::cmd_pkt_t       o_cmd,

    // Response packet in
    input  logic                         i_rsp_valid,
    output logic                         o_rsp_ready,
    input  apb_stub_pkg::rsp_pkt_t       i_rsp
);

    typedef enum logic [1:0] {
        IDLE = 2'b01,
        XFER = 2'b10
    } state_t;

    state_t r_state;
    state_t w_next_state;

    // Command is a direct copy of the access phase signals
    assign o_cmd.pwrite = i_pwrite;
    assign o_cmd.pprot  = i_pprot;
    assign o_cmd.pstrb  = i_pstrb;
    assign o_cmd.paddr  = i_paddr;
    assign o_cmd.pwdata = i_pwdata;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_state <= IDLE;
        end else begin
            r_state <= w_next_state;
        end
    end

    always_comb begin
        w_next_state = r_state;
        o_cmd_valid  = 1'b0;
        o_rsp_ready  = 1'b0;
        o_pready     = 1'b0;
        o_pslverr    = 1'b0;
        o_prdata     = '0;

        case (r_state)
            IDLE: begin
                // Push once the access phase starts and there is room
                if (i_psel && i_penable && i_cmd_ready) begin
                    o_cmd_valid  = 1'b1;
                    w_next_state = XFER;
                end
            end

            XFER: begin
                if (i_rsp_valid) begin
                    o_pready     = 1'b1;
                    o_pslverr    = i_rsp.pslverr;
                    o_prdata     = i_rsp.prdata;
                    o_rsp_ready  = 1'b1;
                    w_next_state = IDLE;
                end
            end

            default: begin
                w_next_state = IDLE;
            end
        endcase
    end

endmodule : apb_slave_stub

/* hdl/apb_stub_macros.svh */
`ifndef APB_STUB_MACROS_SVH
`define APB_STUB_MACROS_SVH

// APB bus widths
`define APB_DATA_WIDTH 32
`define APB_ADDR_WIDTH 12
`define APB_STRB_WIDTH (`APB_DATA_WIDTH / 8)

// Register bank geometry
`define APB_REG_COUNT 16

// Entries per skid buffer, 2 or 4
`define APB_SKID_DEPTH 2

// Word 0 identification constant
`define APB_ID_VALUE 32'hA9B5_0001

`endif

/* hdl/apb_stub_pkg.sv */
`include "apb_stub_macros.svh"

package apb_stub_pkg;

    // One APB transfer as seen by the register bank
    typedef struct packed {
        logic                         pwrite;
        logic [2:0]                   pprot;
        logic [`APB_STRB_WIDTH-1:0]   pstrb;
        logic [`APB_ADDR_WIDTH-1:0]   paddr;
        logic [`APB_DATA_WIDTH-1:0]   pwdata;
    } cmd_pkt_t;

    // Completion returned to the bridge
    typedef struct packed {
        logic                         pslverr;
        logic [`APB_DATA_WIDTH-1:0]   prdata;
    } rsp_pkt_t;

endpackage : apb_stub_pkg

/* hdl/apb_stub_top.sv */
`timescale 1ns/10ps
`include "apb_stub_macros.svh"

module apb_stub_top (
    input  logic                         aclk,
    input  logic                         aresetn,

    input  logic                         i_psel,
    input  logic                         i_penable,
    input  logic [`APB_ADDR_WIDTH-1:0]   i_paddr,
    input  logic                         i_pwrite,
    input  logic [`APB_DATA_WIDTH-1:0]   i_pwdata,
    input  logic [`APB_STRB_WIDTH-1:0]   i_pstrb,
    input  logic [2:0]                   i_pprot,
    output logic [`APB_DATA_WIDTH-1:0]   o_prdata,
    output logic                         o_pslverr,
    output logic                         o_pready
);

    localparam int CMD_W = $bits(apb_stub_pkg::cmd_pkt_t);
    localparam int RSP_W = $bits(apb_stub_pkg::rsp_pkt_t);

    // Bridge to command buffer
    logic                   w_cmd_valid;
    logic                   w_cmd_ready;
    apb_stub_pkg::cmd_pkt_t w_cmd;

    // Command buffer to bank
    logic                   w_bank_cmd_valid;
    logic                   w_bank_cmd_ready;
    apb_stub_pkg::cmd_pkt_t w_bank_cmd;

    // Bank to response buffer
    logic                   w_bank_rsp_valid;
    logic                   w_bank_rsp_ready;
    apb_stub_pkg::rsp_pkt_t w_bank_rsp;

    // Response buffer to bridge
    logic                   w_rsp_valid;
    logic                   w_rsp_ready;
    apb_stub_pkg::rsp_pkt_t w_rsp;

    apb_slave_stub apb_slave_stub_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_paddr     (i_paddr),
        .i_pwrite    (i_pwrite),
        .i_pwdata    (i_pwdata),
        .i_pstrb     (i_pstrb),
        .i_pprot     (i_pprot),
        .o_prdata    (o_prdata),
        .o_pslverr   (o_pslverr),
        .o_pready    (o_pready),
        .o_cmd_valid (w_cmd_valid),
        .i_cmd_ready (w_cmd_ready),
        .o_cmd       (w_cmd),
        .i_rsp_valid (w_rsp_valid),
        .o_rsp_ready (w_rsp_ready),
        .i_rsp       (w_rsp)
    );

    axi_skid_buffer #(
        .DEPTH     (`APB_SKID_DEPTH),
        .PKT_WIDTH (CMD_W)
    ) cmd_skid (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_valid (w_cmd_valid),
        .o_wr_ready (w_cmd_ready),
        .i_wr_data  (w_cmd),
        .o_rd_valid (w_bank_cmd_valid),
        .i_rd_ready (w_bank_cmd_ready),
        .o_rd_data  (w_bank_cmd)
    );

    reg_bank_responder reg_bank_responder_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_cmd_valid (w_bank_cmd_valid),
        .o_cmd_ready (w_bank_cmd_ready),
        .i_cmd       (w_bank_cmd),
        .o_rsp_valid (w_bank_rsp_valid),
        .i_rsp_ready (w_bank_rsp_ready),
        .o_rsp       (w_bank_rsp)
    );

    axi_skid_buffer #(
        .DEPTH     (`APB_SKID_DEPTH),
        .PKT_WIDTH (RSP_W)
    ) rsp_skid (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_valid (w_bank_rsp_valid),
        .o_wr_ready (w_bank_rsp_ready),
        .i_wr_data  (w_bank_rsp),
        .o_rd_valid (w_rsp_valid),
        .i_rd_ready (w_rsp_ready),
        .o_rd_data  (w_rsp)
    );

endmodule : apb_stub_top

/* hdl/axi_skid_buffer.sv */
`timescale 1ns/10ps

module axi_skid_buffer #(
    parameter int DEPTH     = 2,
    parameter int PKT_WIDTH = 32
) (
    input  logic                 aclk,
    input  logic                 aresetn,

    input  logic                 i_wr_valid,
    output logic                 o_wr_ready,
    input  logic [PKT_WIDTH-1:0] i_wr_data,

    output logic                 o_rd_valid,
    input  logic                 i_rd_ready,
    output logic [PKT_WIDTH-1:0] o_rd_data
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [PKT_WIDTH-1:0] r_mem [DEPTH];
    logic [PTR_W-1:0]     r_wr_ptr;
    logic [PTR_W-1:0]     r_rd_ptr;
    logic [CNT_W-1:0]     r_count;
    logic [CNT_W-1:0]     w_count_next;
    logic                 r_wr_ready;
    logic                 r_rd_valid;
    logic                 w_push;
    logic                 w_pop;

    // Both flags come straight from flops, so no ready path runs through
    assign o_wr_ready = r_wr_ready;
    assign o_rd_valid = r_rd_valid;
    assign o_rd_data  = r_mem[r_rd_ptr];

    assign w_push = i_wr_valid && r_wr_ready;
    assign w_pop  = r_rd_valid && i_rd_ready;

    always_comb begin
        w_count_next = r_count;
        case ({w_push, w_pop})
            2'b10:   w_count_next = r_count + 1'b1;
            2'b01:   w_count_next = r_count - 1'b1;
            default: w_count_next = r_count;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_wr_ptr   <= '0;
            r_rd_ptr   <= '0;
            r_count    <= '0;
            r_wr_ready <= 1'b1;
            r_rd_valid <= 1'b0;
        end else begin
            if (w_push) begin
                r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
            end
            if (w_pop) begin
                r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
            end
            r_count    <= w_count_next;
            r_wr_ready <= (w_count_next != CNT_W'(DEPTH));
            r_rd_valid <= (w_count_next != '0);
        end
    end

    // Storage
    always_ff @(posedge aclk) begin
        if (w_push) begin
            r_mem[r_wr_ptr] <= i_wr_data;
        end
    end

endmodule : axi_skid_buffer

/* hdl/reg_bank_responder.sv */
`timescale 1ns/10ps
`include "apb_stub_macros.svh"

module reg_bank_responder (
    input  logic                     aclk,
    input  logic                     aresetn,

    input  logic                     i_cmd_valid,
    output logic                     o_cmd_ready,
    input  apb_stub_pkg::cmd_pkt_t   i_cmd,

    output logic                     o_rsp_valid,
    input  logic                     i_rsp_ready,
    output apb_stub_pkg::rsp_pkt_t   o_rsp
);

    localparam int DW    = `APB_DATA_WIDTH;
    localparam int AW    = `APB_ADDR_WIDTH;
    localparam int SW    = `APB_STRB_WIDTH;
    localparam int NREG  = `APB_REG_COUNT;
    localparam int OFS_W = $clog2(SW);
    localparam int IDX_W = $clog2(NREG);

    // Word 0 is the ID constant and has no storage
    logic [DW-1:0]          r_regs [1:NREG-1];
    logic                   r_rsp_valid;
    apb_stub_pkg::rsp_pkt_t r_rsp;

    logic                   w_accept;
    logic                   w_wr_en;
    logic [IDX_W-1:0]       w_idx;
    logic                   w_misaligned;
    logic                   w_out_of_range;
    logic                   w_id_write;
    logic                   w_nonsec_write;
    logic                   w_error;
    logic [DW-1:0]          w_cur_word;
    logic [DW-1:0]          w_merged;
    apb_stub_pkg::rsp_pkt_t w_rsp_next;

    // One response outstanding at most
    assign o_cmd_ready = !r_rsp_valid;
    assign o_rsp_valid = r_rsp_valid;
    assign o_rsp       = r_rsp;

    assign w_accept = i_cmd_valid && o_cmd_ready;

    // Address decode
    assign w_idx          = i_cmd.paddr[OFS_W +: IDX_W];
    assign w_misaligned   = (i_cmd.paddr[OFS_W-1:0] != '0);
    assign w_out_of_range = (i_cmd.paddr[AW-1:OFS_W+IDX_W] != '0);
    assign w_id_write     = i_cmd.pwrite && (w_idx == '0);
    // Non-secure masters may not write the upper half
    assign w_nonsec_write = i_cmd.pwrite && i_cmd.pprot[1] && (w_idx >= IDX_W'(NREG / 2));
    assign w_error        = w_misaligned || w_out_of_range || w_id_write || w_nonsec_write;

    assign w_wr_en = w_accept && i_cmd.pwrite && !w_error;

    always_comb begin
        if (w_idx == '0) begin
            w_cur_word = `APB_ID_VALUE;
        end else begin
            w_cur_word = r_regs[w_idx];
        end

        // Byte-lane merge
        w_merged = w_cur_word;
        for (int b = 0; b < SW; b++) begin
            if (i_cmd.pstrb[b]) begin
                w_merged[b*8 +: 8] = i_cmd.pwdata[b*8 +: 8];
            end
        end

        // Writes and errors return zero
        w_rsp_next.pslverr = w_error;
        w_rsp_next.prdata  = (w_error || i_cmd.pwrite) ? '0 : w_cur_word;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 1; i < NREG; i++) begin
                r_regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < NREG; i++) begin
                if (w_wr_en && (w_idx == IDX_W'(i))) begin
                    r_regs[i] <= w_merged;
                end
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_rsp_valid <= 1'b0;
        end else if (w_accept) begin
            r_rsp_valid <= 1'b1;
        end else if (i_rsp_ready) begin
            r_rsp_valid <= 1'b0;
        end
    end

    // Response payload
    always_ff @(posedge aclk) begin
        if (w_accept) begin
            r_rsp <= w_rsp_next;
        end
    end

endmodule : reg_bank_responder

/* sim/apb_stub_sva.sv */
`timescale 1ns/10ps

module apb_stub_sva (
    input logic                   aclk,
    input logic                   aresetn,
    input logic                   i_psel,
    input logic                   i_penable,
    input logic                   o_pready,
    input apb_stub_pkg::cmd_pkt_t o_cmd
);

    // Completion only inside an access phase
    a_pready_in_access : assert property (@(posedge aclk) disable iff (!aresetn)
        o_pready |-> (i_psel && i_penable))
        else $error("pready raised outside an APB access phase");

    a_pready_one_cycle : assert property (@(posedge aclk) disable iff (!aresetn)
        o_pready |=> !o_pready)
        else $error("pready held high for more than one cycle");

    // Pending command holds request and payload until completion
    a_cmd_stable : assert property (@(posedge aclk) disable iff (!aresetn)
        (i_psel && i_penable && !o_pready) |=> (i_psel && i_penable && $stable(o_cmd)))
        else $error("command packet changed while stalled");

    a_pready_after_reset : assert property (@(posedge aclk)
        $rose(aresetn) |-> !o_pready)
        else $error("pready high in the first cycle out of reset");

endmodule : apb_stub_sva

bind apb_slave_stub apb_stub_sva apb_stub_sva_i (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .o_pready    (o_pready),
    .o_cmd       (o_cmd)
);

/* sim/apb_stub_tb.sv */
`timescale 1ns/10ps
`include "apb_stub_macros.svh"

module apb_stub_tb;

    localparam int NUM_RANDOM     = 300;
    // Directed phases stay below this count
    localparam int MAX_DIRECTED   = 100;
    localparam int TIMEOUT_CYCLES = (NUM_RANDOM + MAX_DIRECTED) * 16 + 50;

    logic                       aclk;
    logic                       aresetn;
    logic                       psel;
    logic                       penable;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic                       pwrite;
    logic [`APB_DATA_WIDTH-1:0] pwdata;
    logic [`APB_STRB_WIDTH-1:0] pstrb;
    logic [2:0]                 pprot;
    logic [`APB_DATA_WIDTH-1:0] prdata;
    logic                       pslverr;
    logic                       pready;

    logic [`APB_DATA_WIDTH-1:0] model_regs [`APB_REG_COUNT];
    logic [`APB_STRB_WIDTH-1:0] strb_patterns [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};
    apb_stub_pkg::rsp_pkt_t     exp_q [$];
    logic [`APB_ADDR_WIDTH-1:0] addr_q [$];
    apb_stub_pkg::rsp_pkt_t     exp_rsp;
    logic [`APB_ADDR_WIDTH-1:0] exp_addr;
    int                         issued = 0;
    int                         completed = 0;
    int                         mismatches = 0;
    int                         failures = 0;
    int                         cycle_count = 0;

    apb_stub_top apb_stub_top_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_psel    (psel),
        .i_penable (penable),
        .i_paddr   (paddr),
        .i_pwrite  (pwrite),
        .i_pwdata  (pwdata),
        .i_pstrb   (pstrb),
        .i_pprot   (pprot),
        .o_prdata  (prdata),
        .o_pslverr (pslverr),
        .o_pready  (pready)
    );

    always #2 aclk = ~aclk;

    // Expected completion per bank rules; the model changes on good writes only
    function automatic apb_stub_pkg::rsp_pkt_t predict_access(
        input logic                       wr,
        input logic [`APB_ADDR_WIDTH-1:0] addr,
        input logic [`APB_DATA_WIDTH-1:0] data,
        input logic [`APB_STRB_WIDTH-1:0] strb,
        input logic [2:0]                 prot
    );
        apb_stub_pkg::rsp_pkt_t rsp;
        int                     word;
        logic                   err;
        rsp  = '0;
        word = int'(addr >> 2);
        err  = (addr[1:0] != 2'b00) || (word >= `APB_REG_COUNT);
        err  = err || (wr && (word == 0));
        err  = err || (wr && prot[1] && (word >= `APB_REG_COUNT / 2));
        rsp.pslverr = err;
        if (!err && wr) begin
            for (int b = 0; b < `APB_STRB_WIDTH; b++) begin
                if (strb[b]) begin
                    model_regs[word][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end else if (!err) begin
            rsp.prdata = (word == 0) ? `APB_ID_VALUE : model_regs[word];
        end
        return rsp;
    endfunction

    task automatic apb_access(
        input logic                       wr,
        input logic [`APB_ADDR_WIDTH-1:0] addr,
        input logic [`APB_DATA_WIDTH-1:0] data,
        input logic [`APB_STRB_WIDTH-1:0] strb,
        input logic [2:0]                 prot
    );
        exp_q.push_back(predict_access(wr, addr, data, strb, prot));
        addr_q.push_back(addr);
        issued++;
        @(posedge aclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= data;
        pstrb   <= wr ? strb : '0;
        pprot   <= prot;
        @(posedge aclk);
        penable <= 1'b1;
        do begin
            @(posedge aclk);
        end while (!pready);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic print_summary();
        $display("Summary: %0d issued, %0d completed, %0d mismatches, %0d other errors",
                 issued, completed, mismatches, failures);
    endtask

    // Comparator
    always @(posedge aclk) begin
        if (aresetn && pready) begin
            if (exp_q.size() == 0) begin
                failures++;
                $display("pready at %0t with no access outstanding", $time);
            end else begin
                exp_rsp  = exp_q.pop_front();
                exp_addr = addr_q.pop_front();
                completed++;
                if (pslverr !== exp_rsp.pslverr) begin
                    mismatches++;
                    $display("MISMATCH at %0t: addr %h pslverr %b, expected %b",
                             $time, exp_addr, pslverr, exp_rsp.pslverr);
                end
                if (prdata !== exp_rsp.prdata) begin
                    mismatches++;
                    $display("MISMATCH at %0t: addr %h prdata %h, expected %h",
                             $time, exp_addr, prdata, exp_rsp.prdata);
                end
            end
        end
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            failures++;
            $display("Timeout after %0d cycles, an access never completed", cycle_count);
            print_summary();
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        logic                       wr;
        logic [`APB_ADDR_WIDTH-1:0] addr;
        int                         gap;
        void'($urandom(32'h9d32e7b5));
        aclk    = 1'b0;
        aresetn = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        paddr   = '0;
        pwrite  = 1'b0;
        pwdata  = '0;
        pstrb   = '0;
        pprot   = '0;
        for (int i = 0; i < `APB_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;

        // Quiet bus after reset, then the ID word
        repeat (5) begin
            @(posedge aclk);
            if (pready !== 1'b0) begin
                failures++;
                $display("pready went high at %0t with no access on the bus", $time);
            end
        end
        apb_access(1'b0, 12'h000, '0, '0, 3'b000);

        for (int w = 1; w < `APB_REG_COUNT; w++) begin
            apb_access(1'b0, 12'(w * 4), '0, '0, 3'b000);
            apb_access(1'b1, 12'(w * 4), $urandom, 4'hF, 3'b000);
            apb_access(1'b0, 12'(w * 4), '0, '0, 3'b000);
        end

        // Partial strobes over a known word
        for (int w = 1; w <= 4; w++) begin
            apb_access(1'b1, 12'(w * 4), 32'h1122_3344, 4'hF, 3'b000);
            apb_access(1'b1, 12'(w * 4), $urandom, strb_patterns[w - 1], 3'b000);
            apb_access(1'b0, 12'(w * 4), '0, '0, 3'b000);
        end

        apb_access(1'b1, 12'h000, 32'hDEAD_BEEF, 4'hF, 3'b000);
        apb_access(1'b0, 12'h000, '0, '0, 3'b000);
        apb_access(1'b0, 12'h040, '0, '0, 3'b000);
        apb_access(1'b1, 12'h040, 32'h1234_5678, 4'hF, 3'b000);
        apb_access(1'b0, 12'hFFC, '0, '0, 3'b000);
        apb_access(1'b0, 12'h005, '0, '0, 3'b000);
        apb_access(1'b1, 12'h00A, 32'h5555_AAAA, 4'hF, 3'b000);
        apb_access(1'b0, 12'h008, '0, '0, 3'b000);
        // Upper half, non-secure then secure
        for (int w = 8; w < `APB_REG_COUNT; w += 7) begin
            apb_access(1'b1, 12'(w * 4), 32'hBAD0_0000, 4'hF, 3'b010);
            apb_access(1'b0, 12'(w * 4), '0, '0, 3'b010);
            apb_access(1'b1, 12'(w * 4), 32'h600D_0000, 4'hF, 3'b000);
            apb_access(1'b0, 12'(w * 4), '0, '0, 3'b000);
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            wr = 1'($urandom);
            if ($urandom_range(0, 9) < 8) begin
                addr = 12'($urandom_range(0, 15) * 4);
            end else begin
                addr = 12'($urandom);
            end
            apb_access(wr, addr, $urandom, 4'($urandom), 3'($urandom));
            gap = $urandom_range(0, 3);
            repeat (gap) @(posedge aclk);
        end

        repeat (4) @(posedge aclk);
        if (exp_q.size() != 0) begin
            failures++;
            $display("%0d accesses never completed", exp_q.size());
        end
        print_summary();
        if (mismatches == 0 && failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : apb_stub_tb

/* tb.f */
+incdir+hdl
hdl/apb_stub_pkg.sv
hdl/axi_skid_buffer.sv
hdl/apb_slave_stub.sv
hdl/reg_bank_responder.sv
hdl/apb_stub_top.sv
sim/apb_stub_sva.sv
sim/apb_stub_tb.sv
